// ==== Bender.yml ====
package:
  name: m92_cpu_bus

export_include_dirs:
  - .

sources:
  - files:
      - m92_board_pkg.sv
      - m92_bus_pkg.sv
      - m92_bus_stage.sv
      - m92_addr_decode.sv
      - m92_mem_execute.sv
      - m92_read_result.sv
      - m92_cpu_bus.sv
  - target: test
    files:
      - tb_m92_cpu_bus.sv

// ==== m92_addr_decode.sv ====
`timescale 1ns/10ps
`include "m92_params.svh"

module m92_addr_decode (
    input  m92_bus_pkg::cpu_req_t     req,
    input  m92_board_pkg::board_cfg_t board_cfg,
    output m92_bus_pkg::bus_access_t  access
);

    import m92_board_pkg::*;
    import m92_bus_pkg::*;

    cpu_addr_t word_addr;
    cpu_addr_t ram_base;
    cpu_addr_t ram_offset;
    logic      in_rom;
    logic      in_ram;
    logic      in_vidctrl;

    // ==================================================================
    // Window compares
    // ==================================================================

    assign word_addr  = {req.addr[`M92_ADDR_W-1:1], 1'b0};
    assign ram_base   = board_cfg.ram_high ? `M92_RAM_HI_BASE : `M92_RAM_LO_BASE;

    // Below the base this wraps to a large value and misses the window
    assign ram_offset = req.addr - ram_base;

    assign in_rom     = req.addr < `M92_ROM_END;
    assign in_ram     = ram_offset < `M92_RAM_SIZE;
    assign in_vidctrl = word_addr == `M92_VIDCTRL_ADDR;

    // ==================================================================
    // Region select and lane steering
    // ==================================================================

    always_comb begin
        access.odd      = req.addr[0];
        access.write    = req.write;
        access.io_port  = req.addr[7:0];

        // Odd byte rides in the high lane of the word
        if (req.addr[0]) begin
            access.word_data = {req.wdata[7:0], 8'h00};
            access.lane_sel  = {req.byte_sel[0], 1'b0};
        end else begin
            access.word_data = req.wdata;
            access.lane_sel  = req.byte_sel;
        end

        access.region   = REGION_OPEN;
        access.sdr_addr = '0;
        access.writable = 1'b0;

        if (req.io) begin
            access.region   = REGION_IO;
            access.writable = 1'b1;
        end else if (in_vidctrl) begin
            // Wins over the high RAM window it sits inside
            access.region   = REGION_VIDCTRL;
            access.writable = 1'b1;
        end else if (in_rom) begin
            access.region   = REGION_SDRAM;          // Read only
            access.sdr_addr = sdr_addr_t'(req.addr[`M92_ADDR_W-1:1]);
        end else if (in_ram) begin
            access.region   = REGION_SDRAM;
            access.sdr_addr = `M92_SDR_RAM_BASE
                            + sdr_addr_t'(ram_offset[`M92_ADDR_W-1:1]);
            access.writable = 1'b1;
        end
    end

endmodule

// ==== m92_board_pkg.sv ====
package m92_board_pkg;

    // ==================================================================
    // Board configuration
    // ==================================================================

    // Per-game strapping, set from the loader before reset is released
    typedef struct packed {
        logic ram_high;                 // Work RAM at F0000 instead of E0000
    } board_cfg_t;

    // ==================================================================
    // Address regions seen by the main CPU
    // ==================================================================

    typedef enum logic [1:0] {
        REGION_SDRAM   = 2'd0,          // ROM or work RAM, served from SDRAM
        REGION_VIDCTRL = 2'd1,          // Video control latch
        REGION_IO      = 2'd2,          // I/O space, switches and flags
        REGION_OPEN    = 2'd3           // Nothing decodes, bus floats high
    } region_t;

endpackage

// ==== m92_bus_pkg.sv ====
`include "m92_params.svh"

package m92_bus_pkg;

    import m92_board_pkg::region_t;

    typedef logic [`M92_ADDR_W-1:0]     cpu_addr_t;
    typedef logic [`M92_SDR_ADDR_W-1:0] sdr_addr_t;

    // ==================================================================
    // CPU request and response
    // ==================================================================

    // One bus cycle as issued by the CPU, byte address and raw data
    typedef struct packed {
        cpu_addr_t   addr;
        logic [15:0] wdata;
        logic [1:0]  byte_sel;          // Bit 1 high byte, bit 0 low byte
        logic        write;
        logic        io;                // I/O space, port in addr[7:0]
    } cpu_req_t;

    typedef struct packed {
        logic [15:0] rdata;             // Zero for writes
    } cpu_rsp_t;

    // ==================================================================
    // Decoded access, input of the execute stage
    // ==================================================================

    // Data and lanes are already moved to word position
    typedef struct packed {
        region_t     region;
        sdr_addr_t   sdr_addr;
        logic        writable;
        logic [15:0] word_data;
        logic [1:0]  lane_sel;
        logic        odd;               // Byte address was odd
        logic        write;
        logic [7:0]  io_port;
    } bus_access_t;

endpackage

// ==== m92_bus_stage.sv ====
`timescale 1ns/10ps

module m92_bus_stage #(
    parameter type payload_t = logic [15:0]
) (
    input  logic     CLK_32M,
    input  logic     reset_n,

    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,

    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    logic     full;
    payload_t data_q;

    // Refill in the same cycle the consumer drains us
    assign in_ready  = ~full | out_ready;
    assign out_valid = full;
    assign out_data  = data_q;

    always_ff @(posedge CLK_32M or negedge reset_n) begin
        if (!reset_n) begin
            full <= 1'b0;
        end else if (in_ready) begin
            full <= in_valid;
        end
    end

    always_ff @(posedge CLK_32M) begin
        if (in_valid && in_ready) begin
            data_q <= in_data;
        end
    end

endmodule

// ==== m92_cpu_bus.f ====
+incdir+.
m92_board_pkg.sv
m92_bus_pkg.sv
m92_bus_stage.sv
m92_addr_decode.sv
m92_mem_execute.sv
m92_read_result.sv
m92_cpu_bus.sv
tb_m92_cpu_bus.sv

// ==== m92_cpu_bus.sv ====
`timescale 1ns/10ps
`include "m92_params.svh"

module m92_cpu_bus (
    input  logic                       CLK_32M,
    input  logic                       reset_n,
    input  m92_board_pkg::board_cfg_t  board_cfg,

    input  logic                       req_valid,
    output logic                       req_ready,
    input  m92_bus_pkg::cpu_req_t      req,

    output logic                       rsp_valid,
    input  logic                       rsp_ready,
    output m92_bus_pkg::cpu_rsp_t      rsp,

    output logic [`M92_SDR_ADDR_W-1:0] sdr_addr,
    output logic [15:0]                sdr_din,
    output logic [1:0]                 sdr_wr_sel,
    output logic                       sdr_req,
    input  logic [15:0]                sdr_dout,
    input  logic                       sdr_rdy,

    input  logic [3:0]                 p1_joystick,
    input  logic [3:0]                 p1_buttons,
    input  logic [3:0]                 p2_joystick,
    input  logic [3:0]                 p2_buttons,
    input  logic [1:0]                 coin,
    input  logic [1:0]                 start_buttons,
    input  logic [15:0]                dip_sw,

    input  logic                       dbg_io_write,
    input  logic [7:0]                 dbg_io_data,
    output logic                       dbg_io_wait,

    output logic [7:0]                 sys_flags,
    output logic [15:0]                vid_ctrl
);

    import m92_bus_pkg::*;

    cpu_req_t    req_q;
    logic        req_q_valid;
    logic        req_q_ready;
    bus_access_t access;
    logic        exe_valid;
    logic        exe_ready;
    logic [15:0] exe_word;
    logic        exe_odd;
    logic        exe_io;

    // ==================================================================
    // Request register, decode, execute, result
    // ==================================================================

    m92_bus_stage #(
        .payload_t (cpu_req_t)
    ) u_req_stage (
        .CLK_32M   (CLK_32M),
        .reset_n   (reset_n),
        .in_valid  (req_valid),
        .in_ready  (req_ready),
        .in_data   (req),
        .out_valid (req_q_valid),
        .out_ready (req_q_ready),
        .out_data  (req_q)
    );

    m92_addr_decode u_decode (
        .req       (req_q),
        .board_cfg (board_cfg),
        .access    (access)
    );

    m92_mem_execute u_execute (
        .CLK_32M       (CLK_32M),
        .reset_n       (reset_n),
        .in_valid      (req_q_valid),
        .in_ready      (req_q_ready),
        .access        (access),
        .out_valid     (exe_valid),
        .out_ready     (exe_ready),
        .out_word      (exe_word),
        .out_odd       (exe_odd),
        .out_io        (exe_io),
        .sdr_addr      (sdr_addr),
        .sdr_din       (sdr_din),
        .sdr_wr_sel    (sdr_wr_sel),
        .sdr_req       (sdr_req),
        .sdr_dout      (sdr_dout),
        .sdr_rdy       (sdr_rdy),
        .p1_joystick   (p1_joystick),
        .p1_buttons    (p1_buttons),
        .p2_joystick   (p2_joystick),
        .p2_buttons    (p2_buttons),
        .coin          (coin),
        .start_buttons (start_buttons),
        .dip_sw        (dip_sw),
        .dbg_io_write  (dbg_io_write),
        .dbg_io_data   (dbg_io_data),
        .dbg_io_wait   (dbg_io_wait),
        .sys_flags     (sys_flags),
        .vid_ctrl      (vid_ctrl)
    );

    m92_read_result u_result (
        .CLK_32M   (CLK_32M),
        .reset_n   (reset_n),
        .in_valid  (exe_valid),
        .in_ready  (exe_ready),
        .in_word   (exe_word),
        .in_odd    (exe_odd),
        .in_io     (exe_io),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp       (rsp)
    );

endmodule

// ==== m92_mem_execute.sv ====
`timescale 1ns/10ps
`include "m92_params.svh"

module m92_mem_execute (
    input  logic                       CLK_32M,
    input  logic                       reset_n,

    input  logic                       in_valid,
    output logic                       in_ready,
    input  m92_bus_pkg::bus_access_t   access,

    output logic                       out_valid,
    input  logic                       out_ready,
    output logic [15:0]                out_word,
    output logic                       out_odd,
    output logic                       out_io,

    output logic [`M92_SDR_ADDR_W-1:0] sdr_addr,
    output logic [15:0]                sdr_din,
    output logic [1:0]                 sdr_wr_sel,
    output logic                       sdr_req,
    input  logic [15:0]                sdr_dout,
    input  logic                       sdr_rdy,

    input  logic [3:0]                 p1_joystick,
    input  logic [3:0]                 p1_buttons,
    input  logic [3:0]                 p2_joystick,
    input  logic [3:0]                 p2_buttons,
    input  logic [1:0]                 coin,
    input  logic [1:0]                 start_buttons,
    input  logic [15:0]                dip_sw,

    input  logic                       dbg_io_write,
    input  logic [7:0]                 dbg_io_data,
    output logic                       dbg_io_wait,

    output logic [7:0]                 sys_flags,
    output logic [15:0]                vid_ctrl
);

    import m92_board_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SDR_WAIT,
        ST_HOLD
    } state_t;

    state_t      state;
    logic        take;
    logic        is_sdr;
    logic        is_io;
    logic        wr_ok;
    logic [7:0]  dbg_latch;
    logic [15:0] io_word;
    logic [15:0] local_word;
    logic [15:0] res_word;
    logic        res_odd;
    logic        res_io;
    logic        res_write;

    assign in_ready  = (state == ST_IDLE) || (state == ST_HOLD && out_ready);
    assign take      = in_valid && in_ready;
    assign is_sdr    = access.region == REGION_SDRAM;
    assign is_io     = access.region == REGION_IO;
    assign wr_ok     = access.write && access.writable;

    assign out_valid = state == ST_HOLD;
    assign out_word  = res_word;
    assign out_odd   = res_odd;
    assign out_io    = res_io;

    // ==================================================================
    // Local read data
    // ==================================================================

    always_comb begin
        case ({access.io_port[7:1], 1'b0})
            8'h00:   io_word = {p2_buttons, p2_joystick, p1_buttons, p1_joystick};
            8'h02:   io_word = {8'hff, 1'b1, 3'b111, coin, start_buttons}; // No DMA, always idle
            8'h04:   io_word = dip_sw;
            8'h06:   io_word = {dbg_latch, dbg_latch};
            default: io_word = 16'hffff;
        endcase

        if (access.write)
            local_word = 16'h0000;
        else if (is_io)
            local_word = io_word;
        else
            local_word = 16'hffff;                  // Video control is write only
    end

    // ==================================================================
    // Access FSM
    // ==================================================================

    always_ff @(posedge CLK_32M or negedge reset_n) begin
        if (!reset_n) begin
            state   <= ST_IDLE;
            sdr_req <= 1'b0;
        end else begin
            sdr_req <= 1'b0;                        // Single cycle pulse
            case (state)
                ST_IDLE, ST_HOLD: begin
                    if (take && is_sdr) begin
                        state   <= ST_SDR_WAIT;
                        sdr_req <= 1'b1;
                    end else if (take) begin
                        state <= ST_HOLD;
                    end else if (state == ST_HOLD && out_ready) begin
                        state <= ST_IDLE;
                    end
                end
                ST_SDR_WAIT: begin
                    if (sdr_rdy) state <= ST_HOLD;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge CLK_32M) begin
        if (take) begin
            res_odd   <= access.odd;
            res_io    <= is_io;
            res_write <= access.write;
            res_word  <= local_word;
            if (is_sdr) begin
                sdr_addr   <= access.sdr_addr;
                sdr_din    <= access.word_data;
                sdr_wr_sel <= wr_ok ? access.lane_sel : 2'b00; // ROM writes become reads
            end
        end else if (state == ST_SDR_WAIT && sdr_rdy) begin
            res_word <= res_write ? 16'h0000 : sdr_dout;
        end
    end

    // ==================================================================
    // Board registers
    // ==================================================================

    always_ff @(posedge CLK_32M or negedge reset_n) begin
        if (!reset_n) begin
            sys_flags   <= 8'h00;
            vid_ctrl    <= 16'h0000;
            dbg_latch   <= 8'hff;
            dbg_io_wait <= 1'b0;
        end else begin
            if (take && wr_ok && is_io && access.io_port == 8'h02)
                sys_flags <= access.word_data[7:0];
            if (take && wr_ok && access.region == REGION_VIDCTRL)
                vid_ctrl <= access.word_data;

            // Debugger handshake, host write wins over a CPU read
            if (take && is_io && !access.write && access.io_port == 8'h06)
                dbg_io_wait <= 1'b0;
            if (dbg_io_write) begin
                dbg_io_wait <= 1'b1;
                dbg_latch   <= dbg_io_data;
            end
        end
    end

endmodule

// ==== m92_params.svh ====
`ifndef M92_PARAMS_SVH
`define M92_PARAMS_SVH

// ======================================================================
// CPU side address map
// ======================================================================

`define M92_ADDR_W          20                  // V30 physical address width
`define M92_SDR_ADDR_W      25                  // SDRAM word address width

`define M92_ROM_END         20'hC0000           // First address past the program ROM
`define M92_RAM_LO_BASE     20'hE0000           // Work RAM, default board wiring
`define M92_RAM_HI_BASE     20'hF0000           // Work RAM, boards with RAM at F0000
`define M92_RAM_SIZE        20'h10000           // 64 KB work RAM window

// Video control latch occupies one word
`define M92_VIDCTRL_ADDR    20'hF9800

// ======================================================================
// SDRAM layout, word offsets
// ======================================================================

// ROM starts at word 0, work RAM follows at 1M words
`define M92_SDR_RAM_BASE    25'h100000

`endif

// ==== m92_read_result.sv ====
`timescale 1ns/10ps

module m92_read_result (
    input  logic                  CLK_32M,
    input  logic                  reset_n,

    input  logic                  in_valid,
    output logic                  in_ready,
    input  logic [15:0]           in_word,
    input  logic                  in_odd,
    input  logic                  in_io,

    output logic                  rsp_valid,
    input  logic                  rsp_ready,
    output m92_bus_pkg::cpu_rsp_t rsp
);

    import m92_bus_pkg::*;

    cpu_rsp_t shuffled;

    // Byte returned to the CPU always lands in the low lane
    function automatic logic [15:0] lane_return(
        input logic [15:0] word,
        input logic        odd,
        input logic        io
    );
        if (odd)
            lane_return = {8'h00, word[15:8]};
        else if (io)
            lane_return = {8'h00, word[7:0]};     // Ports are byte wide
        else
            lane_return = word;
    endfunction

    always_comb begin
        shuffled.rdata = lane_return(in_word, in_odd, in_io);
    end

    m92_bus_stage #(
        .payload_t (cpu_rsp_t)
    ) u_rsp_stage (
        .CLK_32M   (CLK_32M),
        .reset_n   (reset_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (shuffled),
        .out_valid (rsp_valid),
        .out_ready (rsp_ready),
        .out_data  (rsp)
    );

endmodule

// ==== tb_m92_cpu_bus.sv ====
`timescale 1ns/10ps
`include "m92_params.svh"

module tb_m92_cpu_bus;

    import m92_board_pkg::*;
    import m92_bus_pkg::*;

    localparam int CYCLE_LIMIT = 4000;      // About twice the length of all tests
    localparam int RAM_WORDS   = 32768;     // 64 KB work RAM in words

    logic                       CLK_32M;
    logic                       reset_n;
    board_cfg_t                 board_cfg;
    logic                       req_valid;
    logic                       req_ready;
    cpu_req_t                   req;
    logic                       rsp_valid;
    logic                       rsp_ready = 1'b1;
    cpu_rsp_t                   rsp;
    logic [`M92_SDR_ADDR_W-1:0] sdr_addr;
    logic [15:0]                sdr_din;
    logic [1:0]                 sdr_wr_sel;
    logic                       sdr_req;
    logic [15:0]                sdr_dout;
    logic                       sdr_rdy;
    logic [3:0]                 p1_joystick;
    logic [3:0]                 p1_buttons;
    logic [3:0]                 p2_joystick;
    logic [3:0]                 p2_buttons;
    logic [1:0]                 coin;
    logic [1:0]                 start_buttons;
    logic [15:0]                dip_sw;
    logic                       dbg_io_write;
    logic [7:0]                 dbg_io_data;
    logic                       dbg_io_wait;
    logic [7:0]                 sys_flags;
    logic [15:0]                vid_ctrl;

    integer      seed = 32'h149e_9190;
    int          cycles = 0;
    string       test_name;
    logic [15:0] expect_q [$];              // Expected rdata in issue order
    logic [15:0] sdram_ram [RAM_WORDS];     // Work RAM as seen by the SDRAM model
    logic [15:0] ref_ram [RAM_WORDS];       // Work RAM as the CPU should see it
    logic [1:0]  last_wr_sel;
    logic [7:0]  dbg_value;
    logic        bp_enable = 1'b0;

    m92_cpu_bus dut (.*);

    always #2 CLK_32M = ~CLK_32M;

    // ==================================================================
    // Reporting and reference rules
    // ==================================================================

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [15:0] expected,
                               input logic [15:0] actual);
        if (expected !== actual)
            fail_run($sformatf("MISMATCH %s expected %h actual %h", name, expected, actual));
    endtask

    // Every address bit shows up in the ROM data
    function automatic logic [15:0] rom_pattern(input logic [24:0] a);
        return {a[7:0], a[15:8]} ^ {7'h2b, a[24:16]};
    endfunction

    function automatic logic [15:0] ram_pattern(input logic [14:0] i);
        return {i[7:0], i[14:7]} ^ 16'h3c5a;
    endfunction

    function automatic logic [15:0] io_word_for(input logic [7:0] port);
        case (port & 8'hfe)
            8'h00:   return {p2_buttons, p2_joystick, p1_buttons, p1_joystick};
            8'h02:   return {8'hff, 4'hf, coin, start_buttons};
            8'h04:   return dip_sw;
            8'h06:   return {dbg_value, dbg_value};
            default: return 16'hffff;
        endcase
    endfunction

    function automatic cpu_req_t make_req(input logic [19:0] addr, input logic [15:0] wdata,
                                          input logic [1:0] byte_sel, input logic write,
                                          input logic io);
        cpu_req_t r;
        r.addr     = addr;
        r.wdata    = wdata;
        r.byte_sel = byte_sel;
        r.write    = write;
        r.io       = io;
        return r;
    endfunction

    // Expected response, RAM writes are applied to the reference copy
    task automatic model_access(input cpu_req_t r, output logic [15:0] exp);
        logic [15:0] raw;
        logic [15:0] data;
        logic [1:0]  lanes;
        int          a_i;
        int          base_i;
        int          idx;
        a_i    = int'(r.addr);
        base_i = int'(board_cfg.ram_high ? `M92_RAM_HI_BASE : `M92_RAM_LO_BASE);
        raw    = 16'hffff;                      // Open bus
        if (r.io) begin
            raw = io_word_for(r.addr[7:0]);
        end else if ({r.addr[19:1], 1'b0} == `M92_VIDCTRL_ADDR) begin
            raw = 16'hffff;
        end else if (r.addr < `M92_ROM_END) begin
            raw = rom_pattern(25'(r.addr >> 1));
        end else if (a_i >= base_i && a_i < base_i + int'(`M92_RAM_SIZE)) begin
            idx = (a_i - base_i) >> 1;
            if (r.write) begin
                data  = r.addr[0] ? {r.wdata[7:0], 8'h00} : r.wdata;
                lanes = r.addr[0] ? {r.byte_sel[0], 1'b0} : r.byte_sel;
                if (lanes[1]) ref_ram[idx][15:8] = data[15:8];
                if (lanes[0]) ref_ram[idx][7:0]  = data[7:0];
            end
            raw = ref_ram[idx];
        end
        if (r.write)
            exp = 16'h0000;
        else if (r.addr[0])
            exp = {8'h00, raw[15:8]};
        else if (r.io)
            exp = {8'h00, raw[7:0]};
        else
            exp = raw;
    endtask

    // ==================================================================
    // Bus driver, response monitor, SDRAM model
    // ==================================================================

    // Called on a falling edge, returns on the falling edge after the handshake
    task automatic send_req(input cpu_req_t r, input logic [15:0] exp);
        req_valid = 1'b1;
        req       = r;
        @(posedge CLK_32M);
        while (!req_ready)
            @(posedge CLK_32M);
        expect_q.push_back(exp);
        @(negedge CLK_32M);
        req_valid = 1'b0;
    endtask

    task automatic drain();
        while (expect_q.size() != 0)
            @(negedge CLK_32M);
    endtask

    task automatic modeled_access(input cpu_req_t r);
        logic [15:0] exp;
        model_access(r, exp);
        send_req(r, exp);
        drain();
    endtask

    task automatic expect_access(input cpu_req_t r, input logic [15:0] exp);
        send_req(r, exp);
        drain();
    endtask

    always @(posedge CLK_32M) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT)
            fail_run("Timeout, the run did not finish within the cycle limit");
    end

    always @(negedge CLK_32M)
        rsp_ready = bp_enable ? 1'($random(seed)) : 1'b1;

    always @(posedge CLK_32M) begin
        if (reset_n && rsp_valid && rsp_ready) begin
            if (expect_q.size() == 0)
                fail_run("A response arrived with no request outstanding");
            else
                check_value(test_name, expect_q.pop_front(), rsp.rdata);
        end
    end

    initial begin : sdram_model
        logic [`M92_SDR_ADDR_W-1:0] a;
        logic [15:0]                d;
        logic [1:0]                 sel;
        int                         idx;
        int                         delay;
        sdr_rdy  = 1'b0;
        sdr_dout = 16'h0000;
        forever begin
            @(posedge CLK_32M);
            if (reset_n && sdr_req) begin
                a           = sdr_addr;
                d           = sdr_din;
                sel         = sdr_wr_sel;
                last_wr_sel = sel;
                delay       = 1 + int'({$random(seed)} % 4);
                repeat (delay - 1) @(posedge CLK_32M);
                @(negedge CLK_32M);
                idx = int'(a) - int'(`M92_SDR_RAM_BASE);
                if (idx >= 0 && idx < RAM_WORDS) begin
                    if (sel[1]) sdram_ram[idx][15:8] = d[15:8];
                    if (sel[0]) sdram_ram[idx][7:0]  = d[7:0];
                    sdr_dout = sdram_ram[idx];
                end else if (sel != 2'b00) begin
                    fail_run("SDRAM write outside the work RAM area");
                end else begin
                    sdr_dout = rom_pattern(a);
                end
                sdr_rdy = 1'b1;                 // One cycle with data
                @(negedge CLK_32M);
                sdr_rdy = 1'b0;
            end
        end
    end

    // ==================================================================
    // Directed tests
    // ==================================================================

    task automatic rom_reads();
        logic [19:0] addrs [4] = '{20'h00000, 20'h12344, 20'h5fffe, 20'hbfffe};
        logic [15:0] w;
        test_name = "rom_reads";
        for (int i = 0; i < 4; i++) begin
            w = rom_pattern(25'(addrs[i] >> 1));
            expect_access(make_req(addrs[i], 16'h0000, 2'b11, 1'b0, 1'b0), w);
            expect_access(make_req(addrs[i] | 20'h1, 16'h0000, 2'b01, 1'b0, 1'b0),
                          {8'h00, w[15:8]});
        end
        test_name   = "rom_write";
        last_wr_sel = 2'b11;
        expect_access(make_req(20'h12344, 16'hdead, 2'b11, 1'b1, 1'b0), 16'h0000);
        check_value(test_name, 16'h0000, 16'(last_wr_sel));   // Issued as a read
        expect_access(make_req(20'h12344, 16'h0000, 2'b11, 1'b0, 1'b0),
                      rom_pattern(25'h091a2));
    endtask

    task automatic ram_byte_writes(input logic high);
        logic [19:0] offs [3] = '{20'h00000, 20'h00abc, 20'h0fffe};
        logic [19:0] base;
        logic [19:0] other;
        int          idx;
        board_cfg.ram_high = high;
        test_name = high ? "ram_high" : "ram_low";
        base  = high ? `M92_RAM_HI_BASE : `M92_RAM_LO_BASE;
        other = high ? `M92_RAM_LO_BASE : `M92_RAM_HI_BASE;
        for (int i = 0; i < 3; i++) begin
            idx = int'(offs[i] >> 1);
            modeled_access(make_req(base + offs[i], 16'h1234 ^ offs[i][15:0], 2'b11,
                                    1'b1, 1'b0));
            modeled_access(make_req(base + offs[i] + 20'h1, 16'h55c7, 2'b01, 1'b1, 1'b0));
            modeled_access(make_req(base + offs[i], 16'hee39, 2'b01, 1'b1, 1'b0));
            check_value(test_name, ref_ram[idx], sdram_ram[idx]);
            modeled_access(make_req(base + offs[i], 16'h0000, 2'b11, 1'b0, 1'b0));
            modeled_access(make_req(base + offs[i] + 20'h1, 16'h0000, 2'b01, 1'b0, 1'b0));
            modeled_access(make_req(base + offs[i], 16'h7eee, 2'b10, 1'b1, 1'b0));
            check_value(test_name, ref_ram[idx], sdram_ram[idx]);
            modeled_access(make_req(base + offs[i], 16'h0000, 2'b11, 1'b0, 1'b0));
        end
        // The other window floats
        expect_access(make_req(other + 20'h0100, 16'h0000, 2'b11, 1'b0, 1'b0), 16'hffff);
    endtask

    task automatic io_port_reads();
        logic [7:0]  ports [8] = '{8'h00, 8'h01, 8'h02, 8'h03, 8'h04, 8'h05, 8'h40, 8'h41};
        logic [15:0] w;
        test_name = "io_reads";
        for (int i = 0; i < 8; i++) begin
            w = io_word_for(ports[i]);
            expect_access(make_req({12'h000, ports[i]}, 16'h0000, 2'b01, 1'b0, 1'b1),
                          ports[i][0] ? {8'h00, w[15:8]} : {8'h00, w[7:0]});
        end
    endtask

    task automatic board_registers();
        test_name = "sys_flags";
        check_value(test_name, 16'h0000, 16'(sys_flags));
        expect_access(make_req(20'h00002, 16'h33a6, 2'b01, 1'b1, 1'b1), 16'h0000);
        check_value(test_name, 16'h00a6, 16'(sys_flags));
        test_name = "vid_ctrl";
        check_value(test_name, 16'h0000, vid_ctrl);
        expect_access(make_req(`M92_VIDCTRL_ADDR, 16'h8c31, 2'b11, 1'b1, 1'b0), 16'h0000);
        check_value(test_name, 16'h8c31, vid_ctrl);
        test_name = "dbg_io";
        check_value(test_name, 16'h0000, 16'(dbg_io_wait));
        expect_access(make_req(20'h00006, 16'h0000, 2'b01, 1'b0, 1'b1), 16'h00ff);
        dbg_io_data  = 8'h5a;                   // Host side debugger write
        dbg_io_write = 1'b1;
        dbg_value    = 8'h5a;
        @(negedge CLK_32M);
        dbg_io_write = 1'b0;
        check_value(test_name, 16'h0001, 16'(dbg_io_wait));
        expect_access(make_req(20'h00007, 16'h0000, 2'b01, 1'b0, 1'b1), 16'h005a);
        check_value(test_name, 16'h0001, 16'(dbg_io_wait));
        expect_access(make_req(20'h00006, 16'h0000, 2'b01, 1'b0, 1'b1), 16'h005a);
        check_value(test_name, 16'h0000, 16'(dbg_io_wait));
    endtask

    task automatic backpressure_mix();
        cpu_req_t    r;
        logic [15:0] exp;
        logic [19:0] base;
        int          kind;
        test_name = "backpressure";
        base      = board_cfg.ram_high ? `M92_RAM_HI_BASE : `M92_RAM_LO_BASE;
        bp_enable = 1'b1;
        for (int n = 0; n < 40; n++) begin
            kind = int'({$random(seed)} % 5);
            r    = make_req(20'h0, 16'($random(seed)), 2'($random(seed)),
                            1'($random(seed)), 1'b0);
            case (kind)
                0: r.addr = 20'({$random(seed)} % `M92_ROM_END);
                1: r.addr = base + 20'({$random(seed)} % `M92_RAM_SIZE);
                2: begin
                    r.io   = 1'b1;
                    r.addr = 20'({$random(seed)} % 8);
                end
                3: r.addr = `M92_VIDCTRL_ADDR | 20'($random(seed) & 1);
                default: r.addr = 20'hc0000 + 20'({$random(seed)} % 32'h20000);
            endcase
            model_access(r, exp);
            send_req(r, exp);
            if ({$random(seed)} % 4 == 0)
                @(negedge CLK_32M);             // Idle gap
        end
        drain();
        bp_enable = 1'b0;
        @(negedge CLK_32M);
    endtask

    // ==================================================================
    // Sequence
    // ==================================================================

    initial begin
        CLK_32M       = 1'b0;
        reset_n       = 1'b0;
        board_cfg     = '0;
        req_valid     = 1'b0;
        req           = '0;
        p1_joystick   = 4'h1;
        p1_buttons    = 4'h2;
        p2_joystick   = 4'h3;
        p2_buttons    = 4'h4;
        coin          = 2'b10;
        start_buttons = 2'b01;
        dip_sw        = 16'hb7c4;
        dbg_io_write  = 1'b0;
        dbg_io_data   = 8'h00;
        dbg_value     = 8'hff;
        for (int i = 0; i < RAM_WORDS; i++) begin
            sdram_ram[i] = ram_pattern(15'(i));
            ref_ram[i]   = ram_pattern(15'(i));
        end
        repeat (3) @(posedge CLK_32M);
        @(negedge CLK_32M);
        reset_n = 1'b1;

        test_name = "reset";
        check_value(test_name, 16'h0001, 16'(req_ready));
        check_value(test_name, 16'h0000, 16'(rsp_valid));
        check_value(test_name, 16'h0000, 16'(sdr_req));

        rom_reads();
        ram_byte_writes(1'b0);
        ram_byte_writes(1'b1);
        io_port_reads();
        board_registers();
        backpressure_mix();

        if (expect_q.size() != 0) begin
            fail_run("Responses still outstanding at the end of the run");
        end else begin
            $display("Regression passed");
            $finish;
        end
    end

endmodule
